// File: build.f
+incdir+.
fpu_pkg.sv
fpu_unbox_stage.sv
fpu_exec_stage.sv
fpu_rsp_queue.sv
fpu_lite_top.sv
fpu_lite_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module fpu_lite_tb -o sim_fpu_lite

out=$(./obj_dir/sim_fpu_lite)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

// File: fpu_lite_tb.sv
`timescale 1ns/1ns
`include "fpu_lite_cfg.svh"

module fpu_lite_tb;

  logic                 clk;
  logic                 arst_n;
  logic                 req_valid;
  logic [`FPU_OP_W-1:0] req_op;
  logic                 req_dp;
  fpu_pkg::fp_operand_u req_a;
  fpu_pkg::fp_operand_u req_b;
  logic                 in_credit;
  logic                 rsp_credit;
  logic                 rsp_valid;
  logic [`FPU_XLEN-1:0] rsp_data;
  logic                 rsp_invalid;

  // Expected {invalid, data}, oldest request first
  logic [`FPU_XLEN:0] exp_q[$];
  logic [`FPU_XLEN:0] head_val;
  logic               head_ok;
  logic               rsp_seen, crd_seen;
  logic               hold_credits, timed_out;
  int                 up_credits, credits_owed, granted_total;
  int                 rsp_total, sent_total, in_credit_total, error_count;
  logic [63:0]        dp_cls [10];
  logic [63:0]        sp_cls [10];

  fpu_lite_top dut
    (.clk_i(clk), .arst_n_i(arst_n)
     ,.req_valid_i(req_valid), .req_op_i(req_op), .req_dp_i(req_dp)
     ,.req_a_i(req_a), .req_b_i(req_b), .in_credit_o(in_credit)
     ,.rsp_credit_i(rsp_credit), .rsp_valid_o(rsp_valid)
     ,.rsp_data_o(rsp_data), .rsp_invalid_o(rsp_invalid)
     );

  always #4 clk = ~clk;

  // What the DUT showed at this edge, booked at the next falling edge
  always @(posedge clk or negedge arst_n)
    if (!arst_n)
      begin
        rsp_seen <= 1'b0;
        crd_seen <= 1'b0;
      end
    else
      begin
        rsp_seen <= rsp_valid;
        crd_seen <= in_credit;
      end

  a_rsp_expected: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid |-> head_ok)
    else
      begin
        $display("Response arrived at %0t with no request outstanding", $time);
        error_count++;
      end

  a_rsp_value: assert property (@(posedge clk) disable iff (!arst_n)
    (rsp_valid && head_ok) |-> ({rsp_invalid, rsp_data} == head_val))
    else
      begin
        $display("ERROR %0t: response %h, expected %h", $time, {rsp_invalid, rsp_data}, head_val);
        error_count++;
      end

  a_rsp_credit: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid |-> (rsp_total < granted_total))
    else
      begin
        $display("Response sent at %0t without a downstream credit", $time);
        error_count++;
      end

  a_in_credit: assert property (@(posedge clk) disable iff (!arst_n)
    in_credit == rsp_valid)
    else
      begin
        $display("Credit pulse at %0t does not match the response valid", $time);
        error_count++;
      end

  function automatic logic [63:0] mk_dp(input logic s, input logic [10:0] e, input logic [51:0] f);
    fpu_pkg::fp_operand_u v;
    v.dp.sign = s;
    v.dp.exp  = e;
    v.dp.frac = f;
    return v;
  endfunction

  function automatic logic [63:0] mk_sp(input logic s, input logic [7:0] e, input logic [22:0] f);
    fpu_pkg::fp_operand_u v;
    v.sp.box  = '1;
    v.sp.sign = s;
    v.sp.exp  = e;
    v.sp.frac = f;
    return v;
  endfunction

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [63:0] unbox(input logic [63:0] v, input logic dp);
    if (dp || v[63:32] == 32'hffffffff)
      return v;
    return `FPU_SP_QNAN;
  endfunction

  function automatic logic is_nan(input logic [63:0] v, input logic dp);
    return dp ? (&v[62:52] && |v[51:0]) : (&v[30:23] && |v[22:0]);
  endfunction

  function automatic logic is_snan(input logic [63:0] v, input logic dp);
    return is_nan(v, dp) && !(dp ? v[51] : v[22]);
  endfunction

  function automatic logic is_zero(input logic [63:0] v, input logic dp);
    return dp ? (v[62:0] == '0) : (v[30:0] == '0);
  endfunction

  // Unsigned key that sorts like the float value, -0 just below +0
  function automatic logic [63:0] order_key(input logic [63:0] v, input logic dp);
    if (dp)
      return v[63] ? ~v : {1'b1, v[62:0]};
    return {32'h0, v[31] ? ~v[31:0] : {1'b1, v[30:0]}};
  endfunction

  // Positive classes 4..7 mirror onto 3..0 when negative
  function automatic int class_index(input logic [63:0] v, input logic dp);
    logic e_max;
    logic e_min;
    logic f_nz;
    int   idx;
    e_max = dp ? &v[62:52] : &v[30:23];
    e_min = dp ? ~|v[62:52] : ~|v[30:23];
    f_nz  = dp ? |v[51:0] : |v[22:0];
    if (e_max && f_nz)
      return is_snan(v, dp) ? 8 : 9;
    if (e_max)
      idx = 7;
    else if (!e_min)
      idx = 6;
    else if (f_nz)
      idx = 5;
    else
      idx = 4;
    return (dp ? v[63] : v[31]) ? 7 - idx : idx;
  endfunction

  function automatic logic [63:0] inject(input logic [63:0] v, input logic dp, input logic s);
    return dp ? {s, v[62:0]} : {32'hffffffff, s, v[30:0]};
  endfunction

  function automatic logic [64:0] expected(input logic [3:0] op, input logic dp,
                                           input logic [63:0] a_raw, input logic [63:0] b_raw);
    logic [63:0] a, b, ka, kb, res;
    logic        sa, sb, nan, snan, zeros, inv;
    a     = unbox(a_raw, dp);
    b     = unbox(b_raw, dp);
    ka    = order_key(a, dp);
    kb    = order_key(b, dp);
    sa    = dp ? a[63] : a[31];
    sb    = dp ? b[63] : b[31];
    nan   = is_nan(a, dp) || is_nan(b, dp);
    snan  = is_snan(a, dp) || is_snan(b, dp);
    zeros = is_zero(a, dp) && is_zero(b, dp);
    res   = '0;
    inv   = 1'b0;
    case (op)
      `FPU_OP_FSGNJ:  res = inject(a, dp, sb);
      `FPU_OP_FSGNJN: res = inject(a, dp, !sb);
      `FPU_OP_FSGNJX: res = inject(a, dp, sa ^ sb);
      `FPU_OP_FCLASS: res = 64'd1 << class_index(a, dp);
      `FPU_OP_FMIN, `FPU_OP_FMAX:
        begin
          inv = snan;
          if (is_nan(a, dp) && is_nan(b, dp))
            res = dp ? `FPU_DP_QNAN : `FPU_SP_QNAN;
          else if (is_nan(a, dp))
            res = b;
          else if (is_nan(b, dp))
            res = a;
          else if (op == `FPU_OP_FMIN)
            res = (ka <= kb) ? a : b;
          else
            res = (ka >= kb) ? a : b;
        end
      `FPU_OP_FEQ:
        begin
          inv = snan;
          res = 64'(!nan && (zeros || a == b));
        end
      `FPU_OP_FLT:
        begin
          inv = nan;
          res = 64'(!nan && !zeros && ka < kb);
        end
      `FPU_OP_FLE:
        begin
          inv = nan;
          res = 64'(!nan && (zeros || ka <= kb));
        end
      `FPU_OP_FMVI: res = dp ? a_raw : {{32{a_raw[31]}}, a_raw[31:0]};
      `FPU_OP_IMVF: res = dp ? a_raw : {32'hffffffff, a_raw[31:0]};
      default:      res = '0;
    endcase
    return {inv, res};
  endfunction

  task automatic refresh_head();
    head_ok  = (exp_q.size() != 0);
    head_val = head_ok ? exp_q[0] : '0;
  endtask

  // One cycle of upstream and downstream credit bookkeeping
  task automatic step();
    @(negedge clk);
    req_valid  = 1'b0;
    rsp_credit = 1'b0;
    if (rsp_seen)
      begin
        if (exp_q.size() != 0)
          void'(exp_q.pop_front());
        rsp_total++;
        credits_owed++;
        refresh_head();
      end
    if (crd_seen)
      begin
        up_credits++;
        in_credit_total++;
      end
    if (!hold_credits && credits_owed != 0 && ($urandom % 4) != 0)
      begin
        rsp_credit = 1'b1;
        credits_owed--;
        granted_total++;
      end
  endtask

  task automatic send(input logic [3:0] op, input logic dp, input logic [63:0] a,
                      input logic [63:0] b);
    int waited;
    if (timed_out)
      return;
    step();
    waited = 0;
    while (up_credits == 0 && !timed_out)
      begin
        step();
        waited++;
        if (waited > 100)
          begin
            $display("Timed out waiting for a request credit from the DUT");
            timed_out = 1'b1;
          end
      end
    if (timed_out)
      return;
    req_valid = 1'b1;
    req_op    = op;
    req_dp    = dp;
    req_a     = a;
    req_b     = b;
    up_credits--;
    sent_total++;
    exp_q.push_back(expected(op, dp, a, b));
    refresh_head();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (!timed_out && (exp_q.size() != 0 || credits_owed != 0
                          || up_credits != `FPU_QUEUE_DEPTH))
      begin
        step();
        waited++;
        if (waited > 300)
          begin
            $display("Timed out waiting for outstanding responses to drain");
            timed_out = 1'b1;
          end
      end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %-16s %0d errors", name, error_count - err_before);
  endtask

  initial
    begin
      int err0;
      clk             = 1'b0;
      arst_n          = 1'b0;
      req_valid       = 1'b0;
      req_op          = '0;
      req_dp          = 1'b0;
      req_a           = '0;
      req_b           = '0;
      rsp_credit      = 1'b0;
      hold_credits    = 1'b0;
      timed_out       = 1'b0;
      up_credits      = `FPU_QUEUE_DEPTH;
      granted_total   = `FPU_OUT_CREDITS;
      credits_owed    = 0;
      rsp_total       = 0;
      sent_total      = 0;
      in_credit_total = 0;
      error_count     = 0;
      refresh_head();
      void'($urandom(32'hf01e));

      // One value per class, neg inf first, then snan and qnan
      for (int n = 0; n < 2; n++)
        begin
          dp_cls[n ? 0 : 7] = mk_dp(1'(n), '1, '0);
          dp_cls[n ? 1 : 6] = mk_dp(1'(n), 11'h3f0 + 11'($urandom % 32), 52'(rand64()));
          dp_cls[n ? 2 : 5] = mk_dp(1'(n), '0, 52'(rand64()) | 52'd1);
          dp_cls[n ? 3 : 4] = mk_dp(1'(n), '0, '0);
          sp_cls[n ? 0 : 7] = mk_sp(1'(n), '1, '0);
          sp_cls[n ? 1 : 6] = mk_sp(1'(n), 8'h70 + 8'($urandom % 32), 23'($urandom));
          sp_cls[n ? 2 : 5] = mk_sp(1'(n), '0, 23'($urandom) | 23'd1);
          sp_cls[n ? 3 : 4] = mk_sp(1'(n), '0, '0);
        end
      dp_cls[8] = mk_dp(1'b0, '1, 52'h1);
      dp_cls[9] = mk_dp(1'b1, '1, 52'h8_0000_0000_0000);
      sp_cls[8] = mk_sp(1'b0, '1, 23'h1);
      sp_cls[9] = mk_sp(1'b0, '1, 23'h40_0000);

      repeat (3) @(negedge clk);
      arst_n = 1'b1;

      err0 = error_count;
      for (int op = 0; op < 3; op++)
        for (int i = 0; i < 4; i++)
          begin
            send(4'(`FPU_OP_FSGNJ + op), 1'b1, rand64(), rand64());
            send(4'(`FPU_OP_FSGNJ + op), 1'b0, mk_sp(1'($urandom), 8'($urandom), 23'($urandom)),
                 mk_sp(1'($urandom), 8'($urandom), 23'($urandom)));
            // Box field never all ones
            send(4'(`FPU_OP_FSGNJ + op), 1'b0, {$urandom & 32'h7fffffff, $urandom},
                 mk_sp(1'($urandom), 8'($urandom), 23'($urandom)));
          end
      drain();
      report_test("sign injection", err0);

      err0 = error_count;
      for (int i = 0; i < 10; i++)
        begin
          send(`FPU_OP_FCLASS, 1'b1, dp_cls[i], rand64());
          send(`FPU_OP_FCLASS, 1'b0, sp_cls[i], rand64());
        end
      drain();
      report_test("fclass", err0);

      err0 = error_count;
      for (int op = 0; op < 3; op++)
        for (int i = 0; i < 10; i++)
          for (int j = 0; j < 10; j++)
            begin
              send(4'(`FPU_OP_FEQ + op), 1'b1, dp_cls[i], dp_cls[j]);
              send(4'(`FPU_OP_FEQ + op), 1'b0, sp_cls[i], sp_cls[j]);
            end
      drain();
      report_test("compares", err0);

      err0 = error_count;
      for (int op = 0; op < 2; op++)
        for (int i = 0; i < 10; i++)
          for (int j = 0; j < 10; j++)
            begin
              send(4'(`FPU_OP_FMIN + op), 1'b1, dp_cls[i], dp_cls[j]);
              send(4'(`FPU_OP_FMIN + op), 1'b0, sp_cls[i], sp_cls[j]);
            end
      drain();
      report_test("fmin fmax", err0);

      err0 = error_count;
      for (int i = 0; i < 8; i++)
        begin
          send(`FPU_OP_FMVI, 1'(i), rand64(), rand64());
          send(`FPU_OP_IMVF, 1'(i), rand64(), rand64());
        end
      drain();
      report_test("moves", err0);

      // Hold downstream credits until the queue is full, then release
      err0 = error_count;
      hold_credits = 1'b1;
      for (int i = 0; i < `FPU_QUEUE_DEPTH + `FPU_OUT_CREDITS; i++)
        send(`FPU_OP_FSGNJX, 1'b1, rand64(), rand64());
      repeat (12) step();
      assert (timed_out || rsp_total == granted_total)
        else
          begin
            $display("Responses sent while held do not match the credits granted");
            error_count++;
          end
      hold_credits = 1'b0;
      drain();
      assert (in_credit_total == rsp_total && sent_total == rsp_total)
        else
          begin
            $display("Request, response and credit pulse counts differ");
            error_count++;
          end
      report_test("credits", err0);

      $display("tests 6, responses checked %0d, errors %0d", rsp_total, error_count);
      if (error_count == 0 && !timed_out)
        $display("ALL CHECKS PASSED");
      else
        $display("CHECKS FAILED");
      $finish;
    end

endmodule

// File: fpu_lite_top.sv
`timescale 1ns/1ns
`include "fpu_lite_cfg.svh"

module fpu_lite_top
  (input                          clk_i
   , input                        arst_n_i

   , input                        req_valid_i
   , input [`FPU_OP_W-1:0]        req_op_i
   , input                        req_dp_i
   , input fpu_pkg::fp_operand_u  req_a_i
   , input fpu_pkg::fp_operand_u  req_b_i
   , output logic                 in_credit_o

   , input                        rsp_credit_i
   , output logic                 rsp_valid_o
   , output logic [`FPU_XLEN-1:0] rsp_data_o
   , output logic                 rsp_invalid_o
   );

  logic                 s1_valid;
  logic [`FPU_OP_W-1:0] s1_op;
  logic                 s1_dp;
  fpu_pkg::fp_operand_u s1_a;
  fpu_pkg::fp_operand_u s1_b;
  logic                 s1_a_nan, s1_a_snan, s1_a_inf, s1_a_zero, s1_a_sub;
  logic                 s1_b_nan, s1_b_snan, s1_b_inf, s1_b_zero, s1_b_sub;

  logic                 s2_valid;
  logic [`FPU_XLEN-1:0] s2_data;
  logic                 s2_invalid;

  fpu_unbox_stage unbox
    (.clk_i, .arst_n_i
     ,.req_valid_i, .req_op_i, .req_dp_i, .req_a_i, .req_b_i
     ,.s1_valid_o(s1_valid), .s1_op_o(s1_op), .s1_dp_o(s1_dp), .s1_a_o(s1_a), .s1_b_o(s1_b)
     ,.s1_a_nan_o(s1_a_nan), .s1_a_snan_o(s1_a_snan), .s1_a_inf_o(s1_a_inf)
     ,.s1_a_zero_o(s1_a_zero), .s1_a_sub_o(s1_a_sub)
     ,.s1_b_nan_o(s1_b_nan), .s1_b_snan_o(s1_b_snan), .s1_b_inf_o(s1_b_inf)
     ,.s1_b_zero_o(s1_b_zero), .s1_b_sub_o(s1_b_sub)
     );

  fpu_exec_stage exec
    (.clk_i, .arst_n_i
     ,.s1_valid_i(s1_valid), .s1_op_i(s1_op), .s1_dp_i(s1_dp), .s1_a_i(s1_a), .s1_b_i(s1_b)
     ,.s1_a_nan_i(s1_a_nan), .s1_a_snan_i(s1_a_snan), .s1_a_inf_i(s1_a_inf)
     ,.s1_a_zero_i(s1_a_zero), .s1_a_sub_i(s1_a_sub)
     ,.s1_b_nan_i(s1_b_nan), .s1_b_snan_i(s1_b_snan), .s1_b_inf_i(s1_b_inf)
     ,.s1_b_zero_i(s1_b_zero), .s1_b_sub_i(s1_b_sub)
     ,.s2_valid_o(s2_valid), .s2_data_o(s2_data), .s2_invalid_o(s2_invalid)
     );

  fpu_rsp_queue rsp_queue
    (.clk_i, .arst_n_i
     ,.s2_valid_i(s2_valid), .s2_data_i(s2_data), .s2_invalid_i(s2_invalid)
     ,.rsp_credit_i, .rsp_valid_o, .rsp_data_o, .rsp_invalid_o, .in_credit_o
     );

endmodule

// File: fpu_rsp_queue.sv
`timescale 1ns/1ns
`include "fpu_lite_cfg.svh"

module fpu_rsp_queue
  (input                          clk_i
   , input                        arst_n_i

   , input                        s2_valid_i
   , input [`FPU_XLEN-1:0]        s2_data_i
   , input                        s2_invalid_i

   , input                        rsp_credit_i
   , output logic                 rsp_valid_o
   , output logic [`FPU_XLEN-1:0] rsp_data_o
   , output logic                 rsp_invalid_o
   , output logic                 in_credit_o
   );

  localparam int ptr_width_lp = $clog2(`FPU_QUEUE_DEPTH);
  localparam int cnt_width_lp = $clog2(`FPU_QUEUE_DEPTH + 1);
  localparam int crd_width_lp = $clog2(`FPU_OUT_CREDITS + 1);

  // Invalid flag rides in the top bit
  logic [`FPU_XLEN:0] mem [`FPU_QUEUE_DEPTH];

  logic [ptr_width_lp-1:0] wr_ptr;
  logic [ptr_width_lp-1:0] rd_ptr;
  logic [cnt_width_lp-1:0] count;
  logic [crd_width_lp-1:0] out_credits;

  // A response on the bus already holds one of the credits
  wire pop = (count != '0) && (out_credits > crd_width_lp'(rsp_valid_o));

  always_ff @(posedge clk_i)
    if (s2_valid_i)
      mem[wr_ptr] <= {s2_invalid_i, s2_data_i};

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
      begin
        wr_ptr      <= '0;
        rd_ptr      <= '0;
        count       <= '0;
        out_credits <= crd_width_lp'(`FPU_OUT_CREDITS);
        rsp_valid_o <= 1'b0;
      end
    else
      begin
        if (s2_valid_i)
          wr_ptr <= (wr_ptr == ptr_width_lp'(`FPU_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        if (pop)
          rd_ptr <= (rd_ptr == ptr_width_lp'(`FPU_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        count       <= count + cnt_width_lp'(s2_valid_i) - cnt_width_lp'(pop);
        out_credits <= out_credits - crd_width_lp'(rsp_valid_o)
                       + crd_width_lp'(rsp_credit_i);
        rsp_valid_o <= pop;
      end

  always_ff @(posedge clk_i)
    if (pop)
      {rsp_invalid_o, rsp_data_o} <= mem[rd_ptr];

  // Each response frees one upstream slot
  assign in_credit_o = rsp_valid_o;

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s2_valid_i |-> (count != cnt_width_lp'(`FPU_QUEUE_DEPTH)));

  a_credit_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_credits <= crd_width_lp'(`FPU_OUT_CREDITS));

  a_valid_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o |-> (out_credits != '0));

endmodule

// File: fpu_exec_stage.sv
`timescale 1ns/1ns
`include "fpu_lite_cfg.svh"

module fpu_exec_stage
  (input                          clk_i
   , input                        arst_n_i

   , input                        s1_valid_i
   , input [`FPU_OP_W-1:0]        s1_op_i
   , input                        s1_dp_i
   , input fpu_pkg::fp_operand_u  s1_a_i
   , input fpu_pkg::fp_operand_u  s1_b_i

   , input                        s1_a_nan_i
   , input                        s1_a_snan_i
   , input                        s1_a_inf_i
   , input                        s1_a_zero_i
   , input                        s1_a_sub_i
   , input                        s1_b_nan_i
   , input                        s1_b_snan_i
   , input                        s1_b_inf_i
   , input                        s1_b_zero_i
   , input                        s1_b_sub_i

   , output logic                 s2_valid_o
   , output logic [`FPU_XLEN-1:0] s2_data_o
   , output logic                 s2_invalid_o
   );

  wire [`FPU_XLEN-1:0] a_bits = s1_a_i;
  wire [`FPU_XLEN-1:0] b_bits = s1_b_i;

  wire sgn_a = s1_dp_i ? s1_a_i.dp.sign : s1_a_i.sp.sign;
  wire sgn_b = s1_dp_i ? s1_b_i.dp.sign : s1_b_i.sp.sign;

  // Sign-free magnitudes with single zero-extended
  wire [`FPU_XLEN-2:0] mag_a = s1_dp_i ? a_bits[`FPU_XLEN-2:0]
                                       : {{`FPU_SP_W{1'b0}}, a_bits[`FPU_SP_W-2:0]};
  wire [`FPU_XLEN-2:0] mag_b = s1_dp_i ? b_bits[`FPU_XLEN-2:0]
                                       : {{`FPU_SP_W{1'b0}}, b_bits[`FPU_SP_W-2:0]};

  wire both_zero = s1_a_zero_i & s1_b_zero_i;
  wire any_nan   = s1_a_nan_i | s1_b_nan_i;
  wire any_snan  = s1_a_snan_i | s1_b_snan_i;

  logic lt;
  wire  eq = both_zero | ((sgn_a == sgn_b) & (mag_a == mag_b));

  always_comb
    if (both_zero)
      lt = 1'b0;
    else if (sgn_a != sgn_b)
      lt = sgn_a;
    else if (sgn_a)
      lt = mag_a > mag_b;
    else
      lt = mag_a < mag_b;

  // Sign injection
  logic inj_sgn;
  always_comb
    case (s1_op_i)
      `FPU_OP_FSGNJN: inj_sgn = ~sgn_b;
      `FPU_OP_FSGNJX: inj_sgn = sgn_a ^ sgn_b;
      default:        inj_sgn = sgn_b;
    endcase

  wire [`FPU_XLEN-1:0] sgnj_res = s1_dp_i
    ? {inj_sgn, a_bits[`FPU_XLEN-2:0]}
    : {{`FPU_SP_W{1'b1}}, inj_sgn, a_bits[`FPU_SP_W-2:0]};

  // One-hot class from neg inf at bit 0 up to qnan at bit 9
  wire       a_norm = ~s1_a_nan_i & ~s1_a_inf_i & ~s1_a_zero_i & ~s1_a_sub_i;
  wire [9:0] fclass = {s1_a_nan_i & ~s1_a_snan_i
                       , s1_a_snan_i
                       , ~sgn_a & s1_a_inf_i
                       , ~sgn_a & a_norm
                       , ~sgn_a & s1_a_sub_i
                       , ~sgn_a & s1_a_zero_i
                       , sgn_a & s1_a_zero_i
                       , sgn_a & s1_a_sub_i
                       , sgn_a & a_norm
                       , sgn_a & s1_a_inf_i};

  // -0 sorts below +0 for min and max
  wire a_first = lt | (both_zero & sgn_a & ~sgn_b);
  wire [`FPU_XLEN-1:0] canon_nan = s1_dp_i ? `FPU_DP_QNAN : `FPU_SP_QNAN;

  logic [`FPU_XLEN-1:0] minmax_res;
  always_comb
    if (s1_a_nan_i & s1_b_nan_i)
      minmax_res = canon_nan;
    else if (s1_a_nan_i)
      minmax_res = b_bits;
    else if (s1_b_nan_i)
      minmax_res = a_bits;
    else if (a_first ^ (s1_op_i == `FPU_OP_FMAX))
      minmax_res = a_bits;
    else
      minmax_res = b_bits;

  logic [`FPU_XLEN-1:0] result;
  logic                 invalid;

  always_comb
    begin
      result  = '0;
      invalid = 1'b0;
      case (s1_op_i)
        `FPU_OP_FSGNJ, `FPU_OP_FSGNJN, `FPU_OP_FSGNJX:
          result = sgnj_res;
        `FPU_OP_FMIN, `FPU_OP_FMAX:
          begin
            result  = minmax_res;
            invalid = any_snan;
          end
        `FPU_OP_FEQ:
          begin
            result  = `FPU_XLEN'(~any_nan & eq);
            invalid = any_snan;
          end
        `FPU_OP_FLT:
          begin
            result  = `FPU_XLEN'(~any_nan & lt);
            invalid = any_nan;
          end
        `FPU_OP_FLE:
          begin
            result  = `FPU_XLEN'(~any_nan & (lt | eq));
            invalid = any_nan;
          end
        `FPU_OP_FCLASS:
          result = `FPU_XLEN'(fclass);
        `FPU_OP_FMVI:
          result = s1_dp_i ? a_bits : `FPU_XLEN'($signed(a_bits[`FPU_SP_W-1:0]));
        `FPU_OP_IMVF:
          result = s1_dp_i ? a_bits : {{`FPU_SP_W{1'b1}}, a_bits[`FPU_SP_W-1:0]};
        default:
          result = '0;
      endcase
    end

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
      s2_valid_o <= 1'b0;
    else
      s2_valid_o <= s1_valid_i;

  always_ff @(posedge clk_i)
    begin
      s2_data_o    <= result;
      s2_invalid_o <= invalid;
    end

  a_op_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s1_valid_i |-> (s1_op_i <= `FPU_OP_IMVF));

endmodule

// File: fpu_unbox_stage.sv
`timescale 1ns/1ns
`include "fpu_lite_cfg.svh"

module fpu_unbox_stage
  (input                          clk_i
   , input                        arst_n_i

   , input                        req_valid_i
   , input [`FPU_OP_W-1:0]        req_op_i
   , input                        req_dp_i
   , input fpu_pkg::fp_operand_u  req_a_i
   , input fpu_pkg::fp_operand_u  req_b_i

   , output logic                 s1_valid_o
   , output logic [`FPU_OP_W-1:0] s1_op_o
   , output logic                 s1_dp_o
   , output fpu_pkg::fp_operand_u s1_a_o
   , output fpu_pkg::fp_operand_u s1_b_o

   , output logic                 s1_a_nan_o
   , output logic                 s1_a_snan_o
   , output logic                 s1_a_inf_o
   , output logic                 s1_a_zero_o
   , output logic                 s1_a_sub_o
   , output logic                 s1_b_nan_o
   , output logic                 s1_b_snan_o
   , output logic                 s1_b_inf_o
   , output logic                 s1_b_zero_o
   , output logic                 s1_b_sub_o
   );

  // Returns {nan, snan, inf, zero, sub}
  function automatic logic [4:0] classify(input fpu_pkg::fp_operand_u v, input logic dp);
    logic exp_ones;
    logic exp_zero;
    logic frac_zero;
    logic quiet_bit;
    if (dp)
      begin
        exp_ones  = &v.dp.exp;
        exp_zero  = ~|v.dp.exp;
        frac_zero = ~|v.dp.frac;
        quiet_bit = v.dp.frac[51];
      end
    else
      begin
        exp_ones  = &v.sp.exp;
        exp_zero  = ~|v.sp.exp;
        frac_zero = ~|v.sp.frac;
        quiet_bit = v.sp.frac[22];
      end
    classify = {exp_ones & ~frac_zero
                , exp_ones & ~frac_zero & ~quiet_bit
                , exp_ones & frac_zero
                , exp_zero & frac_zero
                , exp_zero & ~frac_zero};
  endfunction

  // Moves carry raw bits, no unboxing
  wire raw_move = (req_op_i == `FPU_OP_FMVI) | (req_op_i == `FPU_OP_IMVF);
  wire keep_a   = req_dp_i | raw_move | (&req_a_i.sp.box);
  wire keep_b   = req_dp_i | raw_move | (&req_b_i.sp.box);

  fpu_pkg::fp_operand_u a_unboxed;
  fpu_pkg::fp_operand_u b_unboxed;
  logic [4:0]           a_class;
  logic [4:0]           b_class;

  assign a_unboxed = keep_a ? req_a_i : `FPU_SP_QNAN;
  assign b_unboxed = keep_b ? req_b_i : `FPU_SP_QNAN;
  assign a_class   = classify(a_unboxed, req_dp_i);
  assign b_class   = classify(b_unboxed, req_dp_i);

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
      s1_valid_o <= 1'b0;
    else
      s1_valid_o <= req_valid_i;

  always_ff @(posedge clk_i)
    begin
      s1_op_o <= req_op_i;
      s1_dp_o <= req_dp_i;
      s1_a_o  <= a_unboxed;
      s1_b_o  <= b_unboxed;
      {s1_a_nan_o, s1_a_snan_o, s1_a_inf_o, s1_a_zero_o, s1_a_sub_o} <= a_class;
      {s1_b_nan_o, s1_b_snan_o, s1_b_inf_o, s1_b_zero_o, s1_b_sub_o} <= b_class;
    end

endmodule

// File: fpu_pkg.sv
package fpu_pkg;

  // One 64-bit register word, seen as a double or as a boxed single
  typedef union packed
  {
    struct packed
    {
      logic        sign;
      logic [10:0] exp;
      logic [51:0] frac;
    } dp;

    struct packed
    {
      logic [31:0] box;
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] frac;
    } sp;
  } fp_operand_u;

endpackage

// File: fpu_lite_cfg.svh
`ifndef FPU_LITE_CFG_SVH
`define FPU_LITE_CFG_SVH

// Datapath widths
`define FPU_XLEN 64
`define FPU_SP_W 32
`define FPU_OP_W 4

// Opcode encodings
`define FPU_OP_FSGNJ  4'd0
`define FPU_OP_FSGNJN 4'd1
`define FPU_OP_FSGNJX 4'd2
`define FPU_OP_FMIN   4'd3
`define FPU_OP_FMAX   4'd4
`define FPU_OP_FEQ    4'd5
`define FPU_OP_FLT    4'd6
`define FPU_OP_FLE    4'd7
`define FPU_OP_FCLASS 4'd8
`define FPU_OP_FMVI   4'd9
`define FPU_OP_IMVF   4'd10

// Canonical quiet NaNs, single is NaN-boxed
`define FPU_DP_QNAN 64'h7ff8000000000000
`define FPU_SP_QNAN 64'hffffffff7fc00000

// Response queue entries, also the upstream credit pool
`define FPU_QUEUE_DEPTH 4

// Credits granted by downstream after reset
`define FPU_OUT_CREDITS 2

`endif
